//--- shift_add_mult.f
+incdir+design
design/mult_data_pkg.sv
design/mult_ctrl_pkg.sv
design/control_mult.sv
design/mult_datapath.sv
design/shift_add_mult.sv
test/shift_add_mult_tb.sv

//--- Bender.yml
package:
  name: shift_add_mult

sources:
  - include_dirs:
      - design
    files:
      - design/mult_data_pkg.sv
      - design/mult_ctrl_pkg.sv
      - design/control_mult.sv
      - design/mult_datapath.sv
      - design/shift_add_mult.sv

  - target: test
    include_dirs:
      - design
    files:
      - test/shift_add_mult_tb.sv

//--- test/shift_add_mult_tb.sv
`timescale 1ns/1ps

`include "mult_cfg.svh"

module shift_add_mult_tb
  import mult_data_pkg::*;
;

  localparam int HOLD       = `MULT_DONE_HOLD;
  localparam int RISE_LIMIT = 3 * OPERAND_W + 8;
  localparam int FALL_LIMIT = HOLD + 8;
  localparam int IDLE_LIMIT = RISE_LIMIT + FALL_LIMIT + 8;

  localparam operand_t MAX_OP = '1;
  localparam operand_t TOP_OP = operand_t'(1) << (OPERAND_W - 1);
  localparam operand_t ALT_A  = operand_t'(32'haaaa_aaaa);
  localparam operand_t ALT_B  = operand_t'(32'h5555_5555);

  typedef enum logic [1:0] {
    M_IDLE,
    M_RUN,
    M_HOLD
  } model_state_t;

  logic     clk;
  logic     rst;
  logic     init;
  operand_t op_a;
  operand_t op_b;
  product_t product;
  logic     done;

  model_state_t m_state;
  logic         dut_idle;
  product_t     exp_product;
  int           exp_lat;
  int           run_cycles;
  int           done_run;
  int           value_errors;
  int           timeout_errors;
  integer       seed;

  shift_add_mult shift_add_mult_inst (
    .clk     (clk),
    .rst     (rst),
    .init    (init),
    .op_a    (op_a),
    .op_b    (op_b),
    .product (product),
    .done    (done)
  );

  initial begin
    clk = 1'b0;
    forever #20 clk = ~clk;
  end

  // Latency in cycles from the init-sampling edge to done rising is 2k + p
  function automatic int expected_latency(input operand_t b);
    int k;
    int p;
    k = 1;
    p = 0;
    for (int i = 0; i < OPERAND_W; i++) begin
      if (b[i]) begin
        k = i + 1;
        p++;
      end
    end
    return 2 * k + p;
  endfunction

  task automatic report_mismatch(input string msg);
    $display("Fail at %0t ns: %s", $time, msg);
    value_errors++;
  endtask

  // The DUT waits in its start state when no run is open or the window just ended
  assign dut_idle = (m_state == M_IDLE) || (m_state == M_HOLD && !done);

  // Protocol model that runs one edge behind the DUT
  always @(posedge clk) begin
    if (rst) begin
      m_state    <= M_IDLE;
      run_cycles <= 0;
    end else if (dut_idle) begin
      if (init) begin
        m_state     <= M_RUN;
        exp_product <= product_t'(op_a) * product_t'(op_b);
        exp_lat     <= expected_latency(op_b);
        run_cycles  <= 0;
      end else begin
        m_state <= M_IDLE;
      end
    end else if (m_state == M_RUN) begin
      if (done) begin
        m_state <= M_HOLD;
      end else begin
        run_cycles <= run_cycles + 1;
      end
    end
  end

  always @(posedge clk) begin
    if (rst || !done) begin
      done_run <= 0;
    end else begin
      done_run <= done_run + 1;  // Done cycles seen so far
    end
  end

  product_while_done: assert property (@(posedge clk) disable iff (rst)
    done |-> (product == exp_product))
    else report_mismatch($sformatf("product %0h, expected %0h", product, exp_product));

  latency_at_rise: assert property (@(posedge clk) disable iff (rst)
    $rose(done) |-> (run_cycles == exp_lat))
    else report_mismatch($sformatf("latency %0d, expected %0d", run_cycles, exp_lat));

  done_only_after_start: assert property (@(posedge clk) disable iff (rst)
    $rose(done) |-> (m_state == M_RUN))
    else report_mismatch("done rose without a started operation");

  window_not_too_long: assert property (@(posedge clk) disable iff (rst)
    done |-> (done_run <= HOLD))
    else report_mismatch($sformatf("done high for more than %0d cycles", HOLD + 1));

  window_length: assert property (@(posedge clk) disable iff (rst)
    ($fell(done) && !$past(rst)) |-> (done_run == HOLD + 1))
    else report_mismatch($sformatf("done window %0d cycles, expected %0d",
                                   done_run, HOLD + 1));

  idle_product_zero: assert property (@(posedge clk) disable iff (rst)
    (m_state == M_IDLE) |-> (product == '0))
    else report_mismatch($sformatf("idle product %0h, expected 0", product));

  done_low_after_reset: assert property (@(posedge clk)
    $past(rst) |-> !done)
    else report_mismatch("done high after reset");

  task automatic wait_idle(output bit ok);
    int n;
    ok = 1'b0;
    n = 0;
    @(posedge clk);
    init <= 1'b0;
    while (!ok && n < IDLE_LIMIT) begin
      @(negedge clk);
      n++;
      if (m_state == M_IDLE) begin
        ok = 1'b1;
      end
    end
    if (!ok) begin
      $display("Timed out after %0d cycles waiting for the DUT to go idle", n);
      timeout_errors++;
    end
  endtask

  // Random init and operand changes while busy test that they are ignored
  task automatic wait_done_level(input logic level, input int limit, input bit disturb,
                                 output bit ok);
    int n;
    ok = 1'b0;
    n = 0;
    while (!ok && n < limit) begin
      @(posedge clk);
      if (disturb) begin
        init <= 1'($random(seed) & 1);
        op_a <= operand_t'($random(seed));
        op_b <= operand_t'($random(seed));
      end
      @(negedge clk);
      n++;
      if (done == level) begin
        ok = 1'b1;
      end
    end
    if (!ok) begin
      $display("Timed out after %0d cycles waiting for done to go %0d", n, level);
      timeout_errors++;
    end
  endtask

  task automatic launch(input operand_t a, input operand_t b);
    bit ok;
    wait_idle(ok);
    @(posedge clk);
    init <= 1'b1;
    op_a <= a;
    op_b <= b;
    @(posedge clk);
    init <= 1'b0;  // DUT samples init here
  endtask

  task automatic run_op(input operand_t a, input operand_t b, input bit disturb);
    bit ok;
    launch(a, b);
    wait_done_level(1'b1, RISE_LIMIT, disturb, ok);
    if (ok) begin
      wait_done_level(1'b0, FALL_LIMIT, disturb, ok);
    end
  endtask

  task automatic hold_init_high(input operand_t a, input operand_t b, input int count);
    bit ok;
    wait_idle(ok);
    @(posedge clk);
    init <= 1'b1;
    op_a <= a;
    op_b <= b;
    repeat (count) begin
      wait_done_level(1'b1, RISE_LIMIT, 1'b0, ok);
      if (ok) begin
        wait_done_level(1'b0, FALL_LIMIT, 1'b0, ok);
      end
    end
    @(posedge clk);
    init <= 1'b0;
  endtask

  task automatic reset_during(input operand_t a, input operand_t b, input bit in_window);
    bit ok;
    launch(a, b);
    if (in_window) begin
      wait_done_level(1'b1, RISE_LIMIT, 1'b0, ok);
    end
    repeat (3) @(posedge clk);
    rst <= 1'b1;
    repeat (2) @(posedge clk);
    rst <= 1'b0;
  endtask

  initial begin
    rst            = 1'b1;
    init           = 1'b0;
    op_a           = '0;
    op_b           = '0;
    value_errors   = 0;
    timeout_errors = 0;
    seed           = 32'hf216;

    repeat (4) @(posedge clk);
    rst <= 1'b0;

    run_op('0, '0, 1'b0);
    run_op(operand_t'(1), operand_t'(1), 1'b0);
    run_op(MAX_OP, MAX_OP, 1'b0);
    run_op(MAX_OP, operand_t'(1), 1'b0);
    run_op(operand_t'(1), MAX_OP, 1'b0);
    run_op(ALT_A, ALT_B, 1'b0);
    run_op(ALT_B, ALT_A, 1'b0);
    run_op(MAX_OP, TOP_OP, 1'b0);
    run_op(operand_t'(5), '0, 1'b0);

    repeat (200) begin
      run_op(operand_t'($random(seed)), operand_t'($random(seed)), 1'b0);
    end

    hold_init_high(ALT_A, MAX_OP, 3);
    repeat (20) begin
      run_op(operand_t'($random(seed)), operand_t'($random(seed)), 1'b1);
    end

    reset_during(MAX_OP, TOP_OP, 1'b0);  // Mid-computation
    run_op(ALT_B, MAX_OP, 1'b0);
    reset_during(ALT_A, ALT_B, 1'b1);    // Mid done window
    run_op(MAX_OP, ALT_A, 1'b0);

    @(posedge clk);
    init <= 1'b0;
    repeat (3) @(posedge clk);

    $display("Errors: %0d value mismatches, %0d timeouts", value_errors, timeout_errors);
    if (value_errors == 0 && timeout_errors == 0) begin
      $display("*** TEST PASSED ***");
    end else begin
      $display("*** TEST FAILED ***");
    end
    $finish;
  end

endmodule

//--- design/shift_add_mult.sv
`timescale 1ns/1ps

module shift_add_mult
  import mult_data_pkg::*;
(
  input  logic     clk,
  input  logic     rst,
  input  logic     init,
  input  operand_t op_a,
  input  operand_t op_b,
  output product_t product,
  output logic     done
);

  logic lsb_b;
  logic z;
  logic sh;
  logic add;
  logic load;  // Idle load strobe from the controller

  control_mult control_mult_inst (
    .clk   (clk),
    .rst   (rst),
    .lsb_b (lsb_b),
    .init  (init),
    .z     (z),
    .done  (done),
    .sh    (sh),
    .reset (load),
    .add   (add)
  );

  mult_datapath mult_datapath_inst (
    .clk     (clk),
    .rst     (rst),
    .reset   (load),
    .add     (add),
    .sh      (sh),
    .op_a    (op_a),
    .op_b    (op_b),
    .lsb_b   (lsb_b),
    .z       (z),
    .product (product)
  );

endmodule

//--- design/mult_datapath.sv
`timescale 1ns/1ps

module mult_datapath
  import mult_data_pkg::*;
(
  input  logic     clk,
  input  logic     rst,
  input  logic     reset,
  input  logic     add,
  input  logic     sh,
  input  operand_t op_a,
  input  operand_t op_b,
  output logic     lsb_b,
  output logic     z,
  output product_t product
);

  product_t mcand;   // Multiplicand, moves left each step
  operand_t mplier;  // Multiplier, moves right each step
  product_t acc;
  logic     load;

  assign load = rst | reset;

  // Multiplicand register
  always_ff @(posedge clk) begin
    if (load) begin
      mcand <= widen(op_a);
    end else if (sh) begin
      mcand <= mcand << 1;
    end
  end

  // Multiplier register
  always_ff @(posedge clk) begin
    if (load) begin
      mplier <= op_b;
    end else if (sh) begin
      mplier <= mplier >> 1;
    end
  end

  // Accumulator, cannot overflow at twice the operand width
  always_ff @(posedge clk) begin
    if (load) begin
      acc <= '0;
    end else if (add) begin
      acc <= acc + mcand;
    end
  end

  assign lsb_b = mplier[0];

  // Multiplier is zero once the current bit is shifted out
  assign z = ~|mplier[OPERAND_W-1:1];

  assign product = acc;

endmodule

//--- design/control_mult.sv
`timescale 1ns/1ps

module control_mult
  import mult_ctrl_pkg::*;
(
  input  logic clk,
  input  logic rst,
  input  logic lsb_b,
  input  logic init,
  input  logic z,
  output logic done,
  output logic sh,
  output logic reset,
  output logic add
);

  ctrl_state_t state;
  ctrl_state_t state_next;
  hold_cnt_t   hold_cnt;
  logic        hold_zero;

  assign hold_zero = (hold_cnt == '0);

  // State register
  always_ff @(posedge clk) begin
    if (rst) begin
      state <= ST_START;
    end else begin
      state <= state_next;
    end
  end

  // Next state
  always_comb begin
    state_next = state;
    case (state)
      ST_START: begin
        if (init) begin
          state_next = ST_CHECK;
        end
      end
      ST_CHECK: begin
        if (lsb_b) begin
          state_next = ST_ADD;
        end else begin
          state_next = ST_SHIFT;
        end
      end
      ST_ADD: begin
        state_next = ST_SHIFT;
      end
      ST_SHIFT: begin
        if (z) begin
          state_next = ST_DONE;  // Nothing left in the multiplier
        end else begin
          state_next = ST_CHECK;
        end
      end
      ST_DONE: begin
        if (hold_zero) begin
          state_next = ST_START;
        end
      end
      default: begin
        state_next = ST_START;
      end
    endcase
  end

  // Done window timer
  always_ff @(posedge clk) begin
    if (rst) begin
      hold_cnt <= HOLD_INIT;
    end else begin
      case (state)
        ST_START: begin
          hold_cnt <= HOLD_INIT;
        end
        ST_DONE: begin
          if (!hold_zero) begin
            hold_cnt <= hold_cnt - hold_cnt_t'(1);
          end
        end
        default: begin
          hold_cnt <= hold_cnt;
        end
      endcase
    end
  end

  // Strobes follow the current state so the datapath acts in that same cycle
  always_comb begin
    done  = 1'b0;
    sh    = 1'b0;
    reset = 1'b0;
    add   = 1'b0;
    case (state)
      ST_START: begin
        reset = 1'b1;  // Load operands, clear accumulator
      end
      ST_ADD: begin
        add = 1'b1;
      end
      ST_SHIFT: begin
        sh = 1'b1;
      end
      ST_DONE: begin
        done = 1'b1;
      end
      default: begin
        done = 1'b0;
      end
    endcase
  end

endmodule

//--- design/mult_ctrl_pkg.sv
`include "mult_cfg.svh"

package mult_ctrl_pkg;

  localparam int unsigned HOLD_W = `MULT_HOLD_WIDTH;

  // Controller states
  typedef enum logic [2:0] {
    ST_START = 3'b000,  // Idle, operands loaded every cycle
    ST_CHECK = 3'b001,  // Look at multiplier bit 0
    ST_SHIFT = 3'b010,
    ST_ADD   = 3'b011,
    ST_DONE  = 3'b100   // Result held for the done window
  } ctrl_state_t;

  // Done window countdown
  typedef logic [HOLD_W-1:0] hold_cnt_t;

  localparam hold_cnt_t HOLD_INIT = hold_cnt_t'(`MULT_DONE_HOLD);

endpackage

//--- design/mult_data_pkg.sv
`include "mult_cfg.svh"

package mult_data_pkg;

  localparam int unsigned OPERAND_W = `MULT_WIDTH;
  localparam int unsigned PRODUCT_W = `MULT_PRODUCT_WIDTH;

  // One unsigned operand
  typedef logic [OPERAND_W-1:0] operand_t;

  // Product, accumulator and shifted multiplicand
  typedef logic [PRODUCT_W-1:0] product_t;

  // Zero-extend an operand to product width
  function automatic product_t widen(input operand_t value);
    product_t result;
    result = '0;
    result[OPERAND_W-1:0] = value;
    return result;
  endfunction

endpackage

//--- design/mult_cfg.svh
`ifndef MULT_CFG_SVH
`define MULT_CFG_SVH

// Operand width in bits, valid from 4 to 32
`define MULT_WIDTH 16

// Product and accumulator width
`define MULT_PRODUCT_WIDTH (2 * `MULT_WIDTH)

// Countdown steps of the done window
// done stays high for MULT_DONE_HOLD + 1 cycles
`define MULT_DONE_HOLD 20

// Hold timer width, enough to hold MULT_DONE_HOLD
`define MULT_HOLD_WIDTH $clog2(`MULT_DONE_HOLD + 1)

`endif
